/* verilog/theiaLite_params.svh */
// Shared widths, opcodes and bus codes for the theiaLite shader core.
// Include in every RTL file; the guard keeps repeated includes harmless.
`ifndef THEIALITE_PARAMS_SVH
`define THEIALITE_PARAMS_SVH

`define WB_WIDTH        32   // Wishbone data and address
`define DATA_WIDTH      32
`define DATA_ADDR_WIDTH 4    // 16 data words
`define INSTR_WIDTH     16
`define ROM_ADDR_WIDTH  8    // 256 instructions

// Opcodes, anything else behaves as NOP
`define OP_NOP  4'd0
`define OP_ADD  4'd1
`define OP_SUB  4'd2
`define OP_AND  4'd3
`define OP_XOR  4'd4
`define OP_MOVI 4'd5
`define OP_ADDI 4'd6
`define OP_RET  4'd15

// Data memory owners
`define OWNER_CONFIG 2'd0
`define OWNER_EXE    2'd1
`define OWNER_IO     2'd2

`define OREG_PIXEL_COLOR 4'd14  // Colour sent per pixel
`define OREG_ADDR_O      4'd15  // Frame base address

// Slave target tags on TGA_I
`define TAG_DATA  2'd0
`define TAG_INSTR 2'd1
`define TAG_CREG  2'd2

`define CREG_START_LSB 0   // 8-bit microcode start
`define CREG_COUNT_LSB 8   // 8-bit pixel count

`endif

/* verilog/theiaPkg.sv */
// Instruction types for theiaLite.
// One 16-bit word, read either as three register operands or as an immediate.
`default_nettype none
`include "theiaLite_params.svh"

package theiaPkg;

  // Register form: dst = src0 op src1
  typedef struct packed {
    logic [3:0]                  opcode;
    logic [`DATA_ADDR_WIDTH-1:0] dst;
    logic [`DATA_ADDR_WIDTH-1:0] src0;
    logic [`DATA_ADDR_WIDTH-1:0] src1;
  } instrRegForm_t;

  // Immediate form for MOVI and ADDI
  typedef struct packed {
    logic [3:0]                  opcode;
    logic [`DATA_ADDR_WIDTH-1:0] dst;
    logic [7:0]                  imm;
  } instrImmForm_t;

  typedef union packed {
    instrRegForm_t r;
    instrImmForm_t i;  // Opcode and dst overlay the register form
  } instr_u;

endpackage

`default_nettype wire

/* verilog/memPortIf.sv */
// One owner's view of the data memory.
// The owner drives addresses and writes; the memory returns two read words.
`timescale 1ns/1ps
`default_nettype none
`include "theiaLite_params.svh"

interface memPortIf;
  logic [`DATA_ADDR_WIDTH-1:0] readAddr0;
  logic [`DATA_ADDR_WIDTH-1:0] readAddr1;
  logic [`DATA_WIDTH-1:0]      readData0;  // Combinational
  logic [`DATA_WIDTH-1:0]      readData1;
  logic                        writeEnable;
  logic [`DATA_ADDR_WIDTH-1:0] writeAddr;
  logic [`DATA_WIDTH-1:0]      writeData;

  modport owner (
    output readAddr0, readAddr1, writeEnable, writeAddr, writeData,
    input  readData0, readData1
  );

  modport memory (
    input  readAddr0, readAddr1, writeEnable, writeAddr, writeData,
    output readData0, readData1
  );
endinterface

`default_nettype wire

/* verilog/dataMemory.sv */
// Sixteen-word data memory with two read ports and one write port.
// busOwner picks which of the three owners reaches the array.
`timescale 1ns/1ps
`default_nettype none
`include "theiaLite_params.svh"

module dataMemory (
  input  logic       Clock,
  input  logic       rst,
  input  logic [1:0] busOwner,
  memPortIf.memory   configPort,
  memPortIf.memory   exePort,
  memPortIf.memory   pixelPort
);

  logic [`DATA_WIDTH-1:0] words [2**`DATA_ADDR_WIDTH];

  logic                        selExe;
  logic                        selIo;
  logic                        selConfig;
  logic                        we;
  logic [`DATA_ADDR_WIDTH-1:0] wa;
  logic [`DATA_WIDTH-1:0]      wd;
  logic [`DATA_WIDTH-1:0]      rd0;
  logic [`DATA_WIDTH-1:0]      rd1;

  assign selExe    = (busOwner == `OWNER_EXE);
  assign selIo     = (busOwner == `OWNER_IO);
  assign selConfig = !selExe && !selIo;  // Unused code falls back to config

  // Owner mux
  assign we = selExe ? exePort.writeEnable : selIo ? pixelPort.writeEnable
                                                   : configPort.writeEnable;
  assign wa = selExe ? exePort.writeAddr : selIo ? pixelPort.writeAddr : configPort.writeAddr;
  assign wd = selExe ? exePort.writeData : selIo ? pixelPort.writeData : configPort.writeData;
  assign rd0 = words[selExe ? exePort.readAddr0 : selIo ? pixelPort.readAddr0
                                                        : configPort.readAddr0];
  assign rd1 = words[selExe ? exePort.readAddr1 : selIo ? pixelPort.readAddr1
                                                        : configPort.readAddr1];

  // Non-owners read zeros
  assign exePort.readData0    = selExe ? rd0 : '0;
  assign exePort.readData1    = selExe ? rd1 : '0;
  assign pixelPort.readData0  = selIo ? rd0 : '0;
  assign pixelPort.readData1  = selIo ? rd1 : '0;
  assign configPort.readData0 = selConfig ? rd0 : '0;
  assign configPort.readData1 = selConfig ? rd1 : '0;

  always_ff @(posedge Clock) begin
    if (rst) begin
      for (int k = 0; k < 2**`DATA_ADDR_WIDTH; k++) words[k] <= '0;
    end else if (we) begin
      words[wa] <= wd;
    end
  end

  // A write from a port that does not own the bus would be lost
  ownerWrite: assert property (@(posedge Clock) disable iff (rst)
    (exePort.writeEnable -> selExe) && (configPort.writeEnable -> selConfig) &&
    (pixelPort.writeEnable -> selIo));

endmodule

`default_nettype wire

/* verilog/executionUnit.sv */
// Microcode engine: instruction memory, program counter and ALU.
// exeReq starts a run at codeStart; RET ends it and raises exeAck.
`timescale 1ns/1ps
`default_nettype none
`include "theiaLite_params.svh"

module executionUnit
  import theiaPkg::*;
(
  input  logic                       Clock,
  input  logic                       rst,
  input  logic                       instrWrite,
  input  logic [`ROM_ADDR_WIDTH-1:0] instrWriteAddr,
  input  instr_u                     instrWriteData,
  input  logic [`ROM_ADDR_WIDTH-1:0] codeStart,
  input  logic                       exeReq,
  output logic                       exeAck,
  memPortIf.owner                    mem
);

  localparam logic [1:0] IDLE  = 2'd0;
  localparam logic [1:0] FETCH = 2'd1;
  localparam logic [1:0] EXEC  = 2'd2;
  localparam logic [1:0] DONE  = 2'd3;  // Waiting for exeReq to drop

  instr_u imem [2**`ROM_ADDR_WIDTH];
  instr_u instr;                          // Current instruction
  logic [1:0]                 state;
  logic [`ROM_ADDR_WIDTH-1:0] pc;
  logic [`DATA_WIDTH-1:0]     immExt;
  logic [`DATA_WIDTH-1:0]     result;
  logic                       writes;

  assign exeAck = (state == DONE);

  always_ff @(posedge Clock) begin
    if (rst) begin
      state <= IDLE;
      pc    <= '0;
    end else begin
      case (state)
        IDLE:  if (exeReq) begin
          pc    <= codeStart;
          state <= FETCH;
        end
        FETCH: begin
          pc    <= pc + 1'b1;
          state <= EXEC;
        end
        EXEC:  state <= (instr.r.opcode == `OP_RET) ? DONE : FETCH;
        DONE:  if (!exeReq) state <= IDLE;  // Four-phase release
      endcase
    end
  end

  // Loader port and fetch register
  always_ff @(posedge Clock) begin
    if (instrWrite) imem[instrWriteAddr] <= instrWriteData;
    if (state == FETCH) instr <= imem[pc];
  end

  // ------------------------------------------------------------------------
  // Operand reads and ALU

  assign immExt = {{(`DATA_WIDTH-8){1'b0}}, instr.i.imm};

  // ADDI accumulates, so port 0 reads its own destination
  assign mem.readAddr0 = (instr.r.opcode == `OP_ADDI) ? instr.i.dst : instr.r.src0;
  assign mem.readAddr1 = instr.r.src1;

  always_comb begin
    result = '0;
    writes = 1'b1;
    case (instr.r.opcode)
      `OP_ADD:  result = mem.readData0 + mem.readData1;
      `OP_SUB:  result = mem.readData0 - mem.readData1;
      `OP_AND:  result = mem.readData0 & mem.readData1;
      `OP_XOR:  result = mem.readData0 ^ mem.readData1;
      `OP_MOVI: result = immExt;
      `OP_ADDI: result = mem.readData0 + immExt;
      default:  writes = 1'b0;             // NOP, RET and spare codes
    endcase
  end

  assign mem.writeEnable = (state == EXEC) && writes;
  assign mem.writeAddr   = instr.r.dst;    // Same bits in both forms
  assign mem.writeData   = result;

  // Memory belongs to this unit only while the request is up
  writeInRun: assert property (@(posedge Clock) disable iff (rst)
    mem.writeEnable |-> exeReq);

endmodule

`default_nettype wire

/* verilog/ioUnit.sv */
// Wishbone side of the core.
// Slave: configuration writes by TGA_I while MST_I is high.
// Master: one pixel write per pixelReq, colour from word 14 to word 15 + index.
`timescale 1ns/1ps
`default_nettype none
`include "theiaLite_params.svh"

module ioUnit (
  input  logic                        Clock,
  input  logic                        rst,
  input  logic                        MST_I,
  input  logic [`WB_WIDTH-1:0]        DAT_I,
  input  logic [`WB_WIDTH-1:0]        ADR_I,
  input  logic                        CYC_I,
  input  logic                        STB_I,
  input  logic                        WE_I,
  input  logic [1:0]                  TGA_I,
  output logic                        ACK_O,
  output logic [`WB_WIDTH-1:0]        DAT_O,
  output logic [`WB_WIDTH-1:0]        ADR_O,
  output logic                        CYC_O,
  output logic                        STB_O,
  output logic                        WE_O,
  input  logic                        ACK_I,
  input  logic                        GNT_I,
  memPortIf.owner                     configPort,
  memPortIf.owner                     pixelPort,
  output logic                        instrWrite,
  output logic [`ROM_ADDR_WIDTH-1:0]  instrWriteAddr,
  output logic [`INSTR_WIDTH-1:0]     instrWriteData,
  output logic                        cregWrite,
  output logic [15:0]                 cregData,
  input  logic [7:0]                  pixelIndex,
  input  logic                        pixelReq,
  output logic                        pixelAck
);

  logic slaveWrite;
  logic accepted;

  // ------------------------------------------------------------------------
  // Slave, writes only

  assign slaveWrite = MST_I && CYC_I && STB_I && WE_I && !ACK_O;  // Idle in ACK cycle

  always_ff @(posedge Clock) begin
    if (rst) ACK_O <= 1'b0;
    else     ACK_O <= slaveWrite;   // Exactly one cycle later
  end

  assign configPort.writeEnable = slaveWrite && (TGA_I == `TAG_DATA);
  assign configPort.writeAddr   = ADR_I[`DATA_ADDR_WIDTH-1:0];
  assign configPort.writeData   = DAT_I;
  assign configPort.readAddr0   = '0;  // Config side never reads
  assign configPort.readAddr1   = '0;

  assign instrWrite     = slaveWrite && (TGA_I == `TAG_INSTR);
  assign instrWriteAddr = ADR_I[`ROM_ADDR_WIDTH-1:0];
  assign instrWriteData = DAT_I[`INSTR_WIDTH-1:0];
  assign cregWrite      = slaveWrite && (TGA_I == `TAG_CREG);
  assign cregData       = DAT_I[15:0];

  // ------------------------------------------------------------------------
  // Master, one write per pixel

  assign pixelPort.readAddr0   = `OREG_PIXEL_COLOR;
  assign pixelPort.readAddr1   = `OREG_ADDR_O;
  assign pixelPort.writeEnable = 1'b0;
  assign pixelPort.writeAddr   = '0;
  assign pixelPort.writeData   = '0;

  assign accepted = STB_O && ACK_I && GNT_I;

  always_ff @(posedge Clock) begin
    if (rst) begin
      {CYC_O, STB_O, WE_O} <= 3'b000;
      pixelAck             <= 1'b0;
    end else if (accepted) begin
      {CYC_O, STB_O, WE_O} <= 3'b000;
      pixelAck             <= 1'b1;
    end else if (pixelReq && !pixelAck && !STB_O) begin
      {CYC_O, STB_O, WE_O} <= 3'b111;
    end else if (!pixelReq) begin
      pixelAck <= 1'b0;
    end
  end

  // Payload latched at cycle start, held through wait states
  always_ff @(posedge Clock) begin
    if (pixelReq && !pixelAck && !STB_O) begin
      DAT_O <= pixelPort.readData0;
      ADR_O <= pixelPort.readData1 + {{(`WB_WIDTH-8){1'b0}}, pixelIndex};
    end
  end

  holdPayload: assert property (@(posedge Clock) disable iff (rst)
    STB_O && !accepted |=> $stable(ADR_O) && $stable(DAT_O) && WE_O);

endmodule

`default_nettype wire

/* verilog/controlUnit.sv */
// Control register and render FSM.
// Per pixel: run microcode, then write the pixel, until the count is reached.
`timescale 1ns/1ps
`default_nettype none
`include "theiaLite_params.svh"

module controlUnit (
  input  logic                       Clock,
  input  logic                       rst,
  input  logic                       MST_I,
  input  logic                       RENDREN_I,
  input  logic                       cregWrite,
  input  logic [15:0]                cregData,
  output logic [`ROM_ADDR_WIDTH-1:0] codeStart,
  output logic [1:0]                 busOwner,
  output logic                       exeReq,
  input  logic                       exeAck,
  output logic                       pixelReq,
  input  logic                       pixelAck,
  output logic [7:0]                 pixelIndex,
  output logic                       DONE_O
);

  localparam logic [2:0] IDLE  = 3'd0;
  localparam logic [2:0] RUN   = 3'd1;
  localparam logic [2:0] WRITE = 3'd2;
  localparam logic [2:0] NEXT  = 3'd3;
  localparam logic [2:0] DONE  = 3'd4;

  logic [15:0] creg;
  logic [7:0]  pixelCount;
  logic [2:0]  state;

  assign codeStart  = creg[`CREG_START_LSB +: `ROM_ADDR_WIDTH];
  assign pixelCount = creg[`CREG_COUNT_LSB +: 8];
  assign DONE_O     = (state == DONE);
  assign busOwner   = (state == RUN) ? `OWNER_EXE : (state == WRITE) ? `OWNER_IO
                                                                     : `OWNER_CONFIG;

  always_ff @(posedge Clock) begin
    if (rst) begin
      creg       <= '0;
      state      <= IDLE;
      exeReq     <= 1'b0;
      pixelReq   <= 1'b0;
      pixelIndex <= '0;
    end else begin
      if (cregWrite) creg <= cregData;
      case (state)
        IDLE: if (RENDREN_I && !MST_I) begin
          pixelIndex <= '0;
          state      <= (pixelCount == 8'd0) ? DONE : RUN;
          exeReq     <= (pixelCount != 8'd0);
        end
        RUN: begin
          if (exeReq && exeAck) exeReq <= 1'b0;
          else if (!exeReq && !exeAck) begin   // Handshake fully closed
            state    <= WRITE;
            pixelReq <= 1'b1;
          end
        end
        WRITE: begin
          if (pixelReq && pixelAck) pixelReq <= 1'b0;
          else if (!pixelReq && !pixelAck) state <= NEXT;
        end
        NEXT: begin
          if (pixelIndex == pixelCount - 8'd1) state <= DONE;  // Last pixel out
          else begin
            pixelIndex <= pixelIndex + 8'd1;
            state      <= RUN;
            exeReq     <= 1'b1;
          end
        end
        DONE:    if (!RENDREN_I) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  oneRequest: assert property (@(posedge Clock) disable iff (rst) !(exeReq && pixelReq));

endmodule

`default_nettype wire

/* verilog/theiaLite.sv */
// Top level of the theiaLite shader core.
// Wishbone slave for configuration, Wishbone master for pixel writes.
`timescale 1ns/1ps
`default_nettype none
`include "theiaLite_params.svh"

module theiaLite
  import theiaPkg::*;
(
  input  logic                 CLK_I,
  input  logic                 rst,
  input  logic                 MST_I,      // Configuration mode
  input  logic                 RENDREN_I,
  input  logic [`WB_WIDTH-1:0] DAT_I,
  output logic [`WB_WIDTH-1:0] DAT_O,
  input  logic [`WB_WIDTH-1:0] ADR_I,
  output logic [`WB_WIDTH-1:0] ADR_O,
  input  logic                 CYC_I,
  input  logic                 STB_I,
  input  logic                 WE_I,
  output logic                 ACK_O,
  output logic                 CYC_O,
  output logic                 STB_O,
  output logic                 WE_O,
  input  logic                 ACK_I,
  input  logic                 GNT_I,      // Arbiter grant
  input  logic [1:0]           TGA_I,      // Slave target tag
  output logic                 DONE_O
);

  logic                       instrWrite;
  logic [`ROM_ADDR_WIDTH-1:0] instrWriteAddr;
  instr_u                     instrWriteData;
  logic                       cregWrite;
  logic [15:0]                cregData;
  logic [`ROM_ADDR_WIDTH-1:0] codeStart;
  logic [1:0]                 busOwner;
  logic                       exeReq;
  logic                       exeAck;
  logic                       pixelReq;
  logic                       pixelAck;
  logic [7:0]                 pixelIndex;

  memPortIf configPort ();
  memPortIf exePort ();
  memPortIf pixelPort ();

  controlUnit i_controlUnit (
    .Clock(CLK_I), .rst, .MST_I, .RENDREN_I, .cregWrite, .cregData, .codeStart,
    .busOwner, .exeReq, .exeAck, .pixelReq, .pixelAck, .pixelIndex, .DONE_O
  );

  executionUnit i_executionUnit (
    .Clock(CLK_I), .rst, .instrWrite, .instrWriteAddr, .instrWriteData, .codeStart,
    .exeReq, .exeAck, .mem(exePort)
  );

  ioUnit i_ioUnit (
    .Clock(CLK_I), .rst, .MST_I, .DAT_I, .ADR_I, .CYC_I, .STB_I, .WE_I, .TGA_I,
    .ACK_O, .DAT_O, .ADR_O, .CYC_O, .STB_O, .WE_O, .ACK_I, .GNT_I,
    .configPort, .pixelPort, .instrWrite, .instrWriteAddr, .instrWriteData,
    .cregWrite, .cregData, .pixelIndex, .pixelReq, .pixelAck
  );

  dataMemory i_dataMemory (
    .Clock(CLK_I), .rst, .busOwner, .configPort, .exePort, .pixelPort
  );

endmodule

`default_nettype wire

/* sim/clockGen.sv */
// Free-running testbench clock.
// Starts low, first rising edge after half a period.
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int PERIOD = 40  // ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* sim/tbTheiaLite.sv */
// Testbench for the theiaLite shader core.
// Loads data, microcode and the control register over the Wishbone slave,
// renders frames and checks every pixel write against a software model.
`timescale 1ns/1ps
`default_nettype none
`include "theiaLite_params.svh"

module tbTheiaLite;

  localparam int MAX_CYCLES = 4000;  // ~30 passes of 20 instr plus 7-cycle waits

  logic                 clk;
  logic                 rst;
  logic                 MST_I;
  logic                 RENDREN_I;
  logic [`WB_WIDTH-1:0] DAT_I;
  logic [`WB_WIDTH-1:0] DAT_O;
  logic [`WB_WIDTH-1:0] ADR_I;
  logic [`WB_WIDTH-1:0] ADR_O;
  logic                 CYC_I;
  logic                 STB_I;
  logic                 WE_I;
  logic                 ACK_O;
  logic                 CYC_O;
  logic                 STB_O;
  logic                 WE_O;
  logic                 ACK_I;
  logic                 GNT_I;
  logic [1:0]           TGA_I;
  logic                 DONE_O;

  // Model state, mirrors what the slave has loaded
  logic [`DATA_WIDTH-1:0]  modelMem [2**`DATA_ADDR_WIDTH];
  logic [`INSTR_WIDTH-1:0] codeMem [2**`ROM_ADDR_WIDTH];
  logic [15:0]             cregModel = '0;
  logic [`WB_WIDTH-1:0]    expAdr [$];    // Expected pixels, in order
  logic [`WB_WIDTH-1:0]    expDat [$];

  logic [31:0]          lfsrState  = 32'h94a752ef;
  int unsigned          cycleCount = 0;
  int unsigned          writeCount = 0;  // Slave strobes issued
  int unsigned          ackCount   = 0;
  int unsigned          pixelsSeen = 0;
  int unsigned          stbCycles  = 0;
  logic                 prevWrite  = 1'b0;
  logic                 holding    = 1'b0;  // Master cycle waiting
  logic [`WB_WIDTH-1:0] heldAdr;
  logic [`WB_WIDTH-1:0] heldDat;

  clockGen #(.PERIOD(40)) i_clockGen (.clk);

  theiaLite i_theiaLite (.CLK_I(clk), .*);

  // --------------------------------------------------------------------------
  // Helpers

  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
      v = {v[30:0], lfsrState[0]};  // One step per bit
    end
    return v;
  endfunction

  function automatic logic [15:0] regInstr(input logic [3:0] op, dst, a, b);
    return {op, dst, a, b};
  endfunction

  function automatic logic [15:0] immInstr(input logic [3:0] op, dst, input logic [7:0] imm);
    return {op, dst, imm};
  endfunction

  // Reference: one microcode pass on the model memory, up to RET
  function automatic void runModel(input logic [7:0] start);
    logic [7:0]  pc;
    logic [15:0] w;
    logic [3:0]  op;
    logic [3:0]  dst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    pc = start;
    for (int n = 0; n < 256; n++) begin
      w   = codeMem[pc];
      pc  = pc + 8'd1;
      op  = w[15:12];
      dst = w[11:8];
      a   = modelMem[w[7:4]];
      b   = modelMem[w[3:0]];
      imm = {24'd0, w[7:0]};
      if (op == `OP_RET) return;
      case (op)
        `OP_ADD:  modelMem[dst] = a + b;
        `OP_SUB:  modelMem[dst] = a - b;
        `OP_AND:  modelMem[dst] = a & b;
        `OP_XOR:  modelMem[dst] = a ^ b;
        `OP_MOVI: modelMem[dst] = imm;
        `OP_ADDI: modelMem[dst] = modelMem[dst] + imm;  // Accumulate
        default:  ;
      endcase
    end
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Called at a rising edge, returns at the edge where ACK_O is seen
  task automatic configWrite(input logic [1:0] tag, input logic [31:0] addr,
                             input logic [31:0] data);
    MST_I <= 1'b1;
    CYC_I <= 1'b1;
    STB_I <= 1'b1;
    WE_I  <= 1'b1;
    TGA_I <= tag;
    ADR_I <= addr;
    DAT_I <= data;
    writeCount++;
    case (tag)
      `TAG_DATA:  modelMem[addr[`DATA_ADDR_WIDTH-1:0]] = data;
      `TAG_INSTR: codeMem[addr[`ROM_ADDR_WIDTH-1:0]] = data[`INSTR_WIDTH-1:0];
      `TAG_CREG:  cregModel = data[15:0];
      default:    ;
    endcase
    do @(posedge clk); while (!ACK_O);
  endtask

  task automatic endConfig();
    CYC_I <= 1'b0;
    STB_I <= 1'b0;
    WE_I  <= 1'b0;
    @(posedge clk);
    checkValue("ACK_O count", ackCount, writeCount);
  endtask

  task automatic renderFrame();
    int count;
    int seenBefore;
    int stbBefore;
    count      = cregModel[`CREG_COUNT_LSB +: 8];
    seenBefore = pixelsSeen;
    stbBefore  = stbCycles;
    for (int p = 0; p < count; p++) begin
      runModel(cregModel[`CREG_START_LSB +: 8]);
      expDat.push_back(modelMem[`OREG_PIXEL_COLOR]);
      expAdr.push_back(modelMem[`OREG_ADDR_O] + p);  // One word per pixel
    end
    MST_I     <= 1'b0;
    RENDREN_I <= 1'b1;
    do @(posedge clk); while (!DONE_O);
    checkValue("pixel writes", pixelsSeen - seenBefore, count);
    if (count == 0) checkValue("STB_O cycles", stbCycles - stbBefore, 0);
    RENDREN_I <= 1'b0;
    @(posedge clk);
    checkValue("DONE_O hold", DONE_O, 1'b1);
    @(posedge clk);
    checkValue("DONE_O fall", DONE_O, 1'b0);  // One cycle after RENDREN_I
  endtask

  // --------------------------------------------------------------------------
  // Monitors and bus responder

  always @(posedge clk) begin : slaveMonitor
    if (!rst) begin
      if (ACK_O) ackCount++;
      checkValue("ACK_O", ACK_O, prevWrite);  // Exactly one per accepted strobe
    end
    // Strobe taken now unless this is the ACK cycle
    prevWrite = !rst && MST_I && CYC_I && STB_I && WE_I && !prevWrite;
  end

  always @(posedge clk) begin : pixelMonitor
    if (!rst) begin
      if (holding) begin
        checkValue("STB_O hold", STB_O, 1'b1);
        checkValue("ADR_O hold", ADR_O, heldAdr);
        checkValue("DAT_O hold", DAT_O, heldDat);
        checkValue("WE_O hold", WE_O, 1'b1);
      end
      holding = 1'b0;
      if (STB_O) begin
        stbCycles++;
        if (ACK_I && GNT_I) begin
          checkValue("pixel write expected", expAdr.size() != 0, 1'b1);
          checkValue("CYC_O", CYC_O, 1'b1);
          checkValue("WE_O", WE_O, 1'b1);
          checkValue("ADR_O", ADR_O, expAdr.pop_front());
          checkValue("DAT_O", DAT_O, expDat.pop_front());
          pixelsSeen++;
        end else begin
          holding = 1'b1;
          heldAdr = ADR_O;
          heldDat = DAT_O;
        end
      end
      if (DONE_O) checkValue("pixels left at DONE_O", expAdr.size(), 0);
    end
  end

  // Withholds ACK_I or GNT_I for 0 to 7 cycles, never both high early
  initial begin : busResponder
    int   waits;
    logic pick;
    forever begin
      @(posedge clk);
      if (STB_O) begin
        waits = randomBits(3);
        repeat (waits) begin
          pick = randomBits(1);
          ACK_I <= pick;
          GNT_I <= !pick;
          @(posedge clk);
        end
        ACK_I <= 1'b1;
        GNT_I <= 1'b1;
        @(posedge clk);      // Accepted here
        ACK_I <= 1'b0;
        GNT_I <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycleCount++;
    if (cycleCount >= MAX_CYCLES) begin
      $display("Checks failed");
      $fatal(1, "Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus

  initial begin : stimulus
    rst       <= 1'b1;
    MST_I     <= 1'b0;
    RENDREN_I <= 1'b0;
    DAT_I     <= '0;
    ADR_I     <= '0;
    CYC_I     <= 1'b0;
    STB_I     <= 1'b0;
    WE_I      <= 1'b0;
    ACK_I     <= 1'b0;
    GNT_I     <= 1'b0;
    TGA_I     <= `TAG_DATA;
    for (int k = 0; k < 2**`DATA_ADDR_WIDTH; k++) modelMem[k] = '0;  // Matches reset
    for (int k = 0; k < 2**`ROM_ADDR_WIDTH; k++) codeMem[k] = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // One pixel, both instruction forms
    for (int k = 0; k < 4; k++) configWrite(`TAG_DATA, k, randomBits(32));
    configWrite(`TAG_DATA, `OREG_ADDR_O, {randomBits(16), 16'h0000});
    configWrite(`TAG_INSTR, 32'h10, regInstr(`OP_ADD, 4, 0, 1));
    configWrite(`TAG_INSTR, 32'h11, regInstr(`OP_SUB, 5, 4, 2));
    configWrite(`TAG_INSTR, 32'h12, regInstr(`OP_AND, 6, 5, 3));
    configWrite(`TAG_INSTR, 32'h13, regInstr(`OP_XOR, 14, 6, 0));
    configWrite(`TAG_INSTR, 32'h14, immInstr(`OP_MOVI, 7, randomBits(8)));
    configWrite(`TAG_INSTR, 32'h15, regInstr(`OP_ADD, 14, 14, 7));
    configWrite(`TAG_INSTR, 32'h16, regInstr(`OP_RET, 0, 0, 0));
    configWrite(`TAG_CREG, 0, {16'd0, 8'd1, 8'h10});
    endConfig();
    renderFrame();

    // ADDI accumulation over 8 pixels
    configWrite(`TAG_DATA, `OREG_PIXEL_COLOR, randomBits(32));
    configWrite(`TAG_DATA, 9, randomBits(32));
    configWrite(`TAG_DATA, `OREG_ADDR_O, {randomBits(20), 12'h000});
    configWrite(`TAG_INSTR, 32'h40, immInstr(`OP_ADDI, 14, randomBits(8)));
    configWrite(`TAG_INSTR, 32'h41, regInstr(`OP_ADD, 14, 14, 9));
    configWrite(`TAG_INSTR, 32'h42, regInstr(`OP_RET, 0, 0, 0));
    configWrite(`TAG_CREG, 0, {16'd0, 8'd8, 8'h40});
    endConfig();
    renderFrame();

    // Second render, new data, same program
    configWrite(`TAG_DATA, 9, randomBits(32));
    configWrite(`TAG_DATA, `OREG_ADDR_O, {randomBits(20), 12'h800});
    configWrite(`TAG_CREG, 0, {16'd0, 8'd5, 8'h40});
    endConfig();
    renderFrame();

    // Zero count: DONE_O without any master cycle
    configWrite(`TAG_CREG, 0, {16'd0, 8'd0, 8'h40});
    endConfig();
    renderFrame();

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* theiaLite.f */
+incdir+verilog
verilog/theiaPkg.sv
verilog/memPortIf.sv
verilog/dataMemory.sv
verilog/executionUnit.sv
verilog/ioUnit.sv
verilog/controlUnit.sv
verilog/theiaLite.sv
sim/clockGen.sv
sim/tbTheiaLite.sv

/* build.sh */
#!/bin/sh
# Compile the theiaLite testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=simTheiaLite

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tbTheiaLite -f theiaLite.f -o "$BIN"; then
  echo "Verilator compile failed"
  exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation returned a failing status"
  exit 1
fi

cat "$LOG"
if grep -q "All checks passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
